// ==== dcache_pkg.sv ====
// data cache shared definitions

package dcache_pkg;

	// address geometry
	localparam int addr_w = 32;
	localparam int tag_w = 23;
	localparam int index_w = 6;
	localparam int offset_w = 3;

	// data word
	localparam int data_w = 64;
	localparam int mask_w = 8;

	localparam int num_sets = 64;
	localparam int num_ways = 2;

	// controller state codes
	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_lookup = 3'd1;
	localparam logic [2:0] st_hit = 3'd2;
	localparam logic [2:0] st_wb = 3'd3;
	localparam logic [2:0] st_refill = 3'd4;
	localparam logic [2:0] st_reread = 3'd5;

	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic [index_w-1:0] index;
		logic [offset_w-1:0] offset;
	} addr_fields_t;

	// flat for memory traffic, fields for lookup
	typedef union packed {
		logic [addr_w-1:0] flat;
		addr_fields_t f;
	} cache_addr_t;

	typedef struct packed {
		cache_addr_t addr;
		logic write;
		logic [data_w-1:0] wdata;
		logic [mask_w-1:0] mask;
	} core_req_t;

	typedef struct packed {
		logic rd_en;
		logic wr_en;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic valid;
		logic [tag_w-1:0] tag;
	} tag_entry_t;

	typedef logic way_sel_t;

endpackage

// ==== dcache_req_stage.sv ====
// core request capture
`timescale 1ns/10ps

module dcache_req_stage
	import dcache_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      req_i,
	input  core_req_t req_data_i,
	input  logic      ack_i,
	output logic      new_req_o,
	output core_req_t held_req_o
);

	logic busy_q;
	logic take;

	// only one request in flight
	assign take = req_i && !busy_q;

	always_ff @(posedge clk) begin
		if (!rst) begin
			busy_q <= 1'b0;
			new_req_o <= 1'b0;
		end else begin
			new_req_o <= take;
			if (take) begin
				busy_q <= 1'b1;
			end else if (ack_i) begin
				busy_q <= 1'b0;
			end
		end
	end

	// address union comes along, the controller reads its fields
	always_ff @(posedge clk) begin
		if (take) begin
			held_req_o <= req_data_i;
		end
	end

endmodule

// ==== dcache_tag_store.sv ====
// tag, valid, dirty and recency storage
`timescale 1ns/10ps

module dcache_tag_store
	import dcache_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic [index_w-1:0]  rd_index_i,
	input  logic                wr_en_i,
	input  way_sel_t            wr_way_i,
	input  tag_entry_t          wr_entry_i,
	input  logic                set_dirty_i,
	input  logic                clr_dirty_i,
	input  logic                touch_i,
	input  way_sel_t            touch_way_i,
	output tag_entry_t          entry0_o,
	output tag_entry_t          entry1_o,
	output logic [num_ways-1:0] dirty_o,
	output way_sel_t            lru_way_o
);

	logic [tag_w-1:0] tag_mem [num_ways][num_sets];
	logic [num_sets-1:0] valid_q [num_ways];
	logic [num_sets-1:0] dirty_q [num_ways];
	logic [num_sets-1:0] lru_q;

	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			tag_mem[wr_way_i][rd_index_i] <= wr_entry_i.tag;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int w = 0; w < num_ways; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
			lru_q <= '0;
		end else begin
			if (wr_en_i) begin
				valid_q[wr_way_i][rd_index_i] <= wr_entry_i.valid;
			end
			// refilled line starts clean
			if (clr_dirty_i) begin
				dirty_q[wr_way_i][rd_index_i] <= 1'b0;
			end
			if (set_dirty_i) begin
				dirty_q[touch_way_i][rd_index_i] <= 1'b1;
			end
			// bit holds the least recently used way
			if (touch_i) begin
				lru_q[rd_index_i] <= ~touch_way_i;
			end
		end
	end

	// registered read port
	always_ff @(posedge clk) begin
		entry0_o.valid <= valid_q[0][rd_index_i];
		entry0_o.tag <= tag_mem[0][rd_index_i];
		entry1_o.valid <= valid_q[1][rd_index_i];
		entry1_o.tag <= tag_mem[1][rd_index_i];
		for (int w = 0; w < num_ways; w++) begin
			dirty_o[w] <= dirty_q[w][rd_index_i];
		end
		lru_way_o <= lru_q[rd_index_i];
	end

endmodule

// ==== dcache_data_store.sv ====
// cached data words, byte writable
`timescale 1ns/10ps

module dcache_data_store
	import dcache_pkg::*;
(
	input  logic               clk,
	input  logic [index_w-1:0] index_i,
	input  logic               wr_en_i,
	input  way_sel_t           way_i,
	input  logic [mask_w-1:0]  mask_i,
	input  logic [data_w-1:0]  wdata_i,
	output logic [data_w-1:0]  rdata0_o,
	output logic [data_w-1:0]  rdata1_o
);

	logic [data_w-1:0] mem [num_ways][num_sets];

	// refill passes a full mask, hit writes pass the core mask
	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			for (int b = 0; b < mask_w; b++) begin
				if (mask_i[b]) begin
					mem[way_i][index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
				end
			end
		end
	end

	// read returns the old word when written in the same cycle
	always_ff @(posedge clk) begin
		rdata0_o <= mem[0][index_i];
		rdata1_o <= mem[1][index_i];
	end

endmodule

// ==== dcache_ctrl.sv ====
// cache controller
// lookup, write-back, refill and hit sequencing
`timescale 1ns/10ps

module dcache_ctrl
	import dcache_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic                new_req_i,
	input  core_req_t           req_i,
	input  tag_entry_t          entry0_i,
	input  tag_entry_t          entry1_i,
	input  logic [num_ways-1:0] dirty_i,
	input  way_sel_t            lru_way_i,
	input  logic [data_w-1:0]   rdata0_i,
	input  logic [data_w-1:0]   rdata1_i,
	input  logic                mem_done_i,
	input  logic [data_w-1:0]   mem_rdata_i,
	output logic [index_w-1:0]  index_o,
	output logic                tag_wr_en_o,
	output way_sel_t            tag_wr_way_o,
	output tag_entry_t          tag_wr_entry_o,
	output logic                set_dirty_o,
	output logic                clr_dirty_o,
	output logic                touch_o,
	output way_sel_t            touch_way_o,
	output logic                data_wr_en_o,
	output way_sel_t            data_way_o,
	output logic [mask_w-1:0]   data_mask_o,
	output logic [data_w-1:0]   data_wdata_o,
	output logic                mem_start_o,
	output mem_req_t            mem_req_o,
	output logic                ack_o,
	output logic [data_w-1:0]   rdata_o
);

	logic [2:0]  state_q;
	logic [2:0]  state_d;
	logic        hit0;
	logic        hit1;
	way_sel_t    hit_way_q;
	way_sel_t    victim_d;
	way_sel_t    victim_q;
	tag_entry_t  victim_entry;
	logic        victim_dirty;
	cache_addr_t wb_addr;
	cache_addr_t fill_addr;
	mem_req_t    fill_req;

	assign index_o = req_i.addr.f.index;

	assign hit0 = entry0_i.valid && (entry0_i.tag == req_i.addr.f.tag);
	assign hit1 = entry1_i.valid && (entry1_i.tag == req_i.addr.f.tag);

	// an empty way wins over the lru way
	always_comb begin
		if (!entry0_i.valid) begin
			victim_d = 1'b0;
		end else if (!entry1_i.valid) begin
			victim_d = 1'b1;
		end else begin
			victim_d = lru_way_i;
		end
	end

	assign victim_entry = victim_d ? entry1_i : entry0_i;
	assign victim_dirty = victim_entry.valid && dirty_i[victim_d];

	always_comb begin
		wb_addr.f.tag = victim_entry.tag;
		wb_addr.f.index = req_i.addr.f.index;
		wb_addr.f.offset = '0;
		fill_addr = req_i.addr;
		fill_addr.f.offset = '0;
	end

	always_comb begin
		fill_req = '0;
		fill_req.rd_en = 1'b1;
		fill_req.addr = fill_addr.flat;
	end

	always_comb begin
		state_d = state_q;
		mem_start_o = 1'b0;
		mem_req_o = '0;
		case (state_q)
			st_idle: begin
				if (new_req_i) begin
					state_d = st_lookup;
				end
			end
			st_lookup: begin
				if (hit0 || hit1) begin
					state_d = st_hit;
				end else if (victim_dirty) begin
					mem_start_o = 1'b1;
					mem_req_o.wr_en = 1'b1;
					mem_req_o.addr = wb_addr.flat;
					mem_req_o.wdata = victim_d ? rdata1_i : rdata0_i;
					state_d = st_wb;
				end else begin
					mem_start_o = 1'b1;
					mem_req_o = fill_req;
					state_d = st_refill;
				end
			end
			st_wb: begin
				if (mem_done_i) begin
					mem_start_o = 1'b1;
					mem_req_o = fill_req;
					state_d = st_refill;
				end
			end
			st_refill: begin
				if (mem_done_i) begin
					state_d = st_reread;
				end
			end
			// stores see the refilled line one cycle later
			st_reread: state_d = st_lookup;
			st_hit: state_d = st_idle;
			default: state_d = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state_q <= st_idle;
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == st_lookup) begin
			hit_way_q <= hit1;
			victim_q <= victim_d;
		end
	end

	always_comb begin
		tag_wr_en_o = 1'b0;
		tag_wr_way_o = victim_q;
		tag_wr_entry_o.valid = 1'b1;
		tag_wr_entry_o.tag = req_i.addr.f.tag;
		clr_dirty_o = 1'b0;
		set_dirty_o = 1'b0;
		touch_o = 1'b0;
		touch_way_o = hit_way_q;
		data_wr_en_o = 1'b0;
		data_way_o = victim_q;
		data_mask_o = '1;
		data_wdata_o = mem_rdata_i;
		if (state_q == st_refill && mem_done_i) begin
			tag_wr_en_o = 1'b1;
			clr_dirty_o = 1'b1;
			data_wr_en_o = 1'b1;
		end
		if (state_q == st_hit) begin
			touch_o = 1'b1;
			set_dirty_o = req_i.write;
			data_wr_en_o = req_i.write;
			data_way_o = hit_way_q;
			data_mask_o = req_i.mask;
			data_wdata_o = req_i.wdata;
		end
	end

	assign ack_o = (state_q == st_hit);
	assign rdata_o = hit_way_q ? rdata1_i : rdata0_i;

endmodule

// ==== dcache_mem_port.sv ====
// memory side request holder
`timescale 1ns/10ps

module dcache_mem_port
	import dcache_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              start_i,
	input  mem_req_t          req_i,
	input  logic              mem_valid_i,
	input  logic [data_w-1:0] mem_rdata_i,
	output mem_req_t          mem_req_o,
	output logic              done_o,
	output logic [data_w-1:0] rdata_o
);

	mem_req_t req_q;
	logic     active;

	assign active = req_q.rd_en || req_q.wr_en;

	always_ff @(posedge clk) begin
		if (!rst) begin
			req_q.rd_en <= 1'b0;
			req_q.wr_en <= 1'b0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (start_i) begin
				req_q <= req_i;
			end else if (mem_valid_i && active) begin
				// address and data stay, only the enables drop
				req_q.rd_en <= 1'b0;
				req_q.wr_en <= 1'b0;
				done_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mem_valid_i && req_q.rd_en) begin
			rdata_o <= mem_rdata_i;
		end
	end

	assign mem_req_o = req_q;

endmodule

// ==== dcache_top.sv ====
// two-way write-back data cache
`timescale 1ns/10ps

module dcache_top
	import dcache_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              req_i,
	input  core_req_t         req_data_i,
	output logic              ack_o,
	output logic [data_w-1:0] rdata_o,
	output mem_req_t          mem_req_o,
	input  logic              mem_valid_i,
	input  logic [data_w-1:0] mem_rdata_i
);

	logic                new_req;
	core_req_t           held_req;
	logic [index_w-1:0]  index;
	tag_entry_t          entry0;
	tag_entry_t          entry1;
	logic [num_ways-1:0] dirty;
	way_sel_t            lru_way;
	logic                tag_wr_en;
	way_sel_t            tag_wr_way;
	tag_entry_t          tag_wr_entry;
	logic                set_dirty;
	logic                clr_dirty;
	logic                touch;
	way_sel_t            touch_way;
	logic                data_wr_en;
	way_sel_t            data_way;
	logic [mask_w-1:0]   data_mask;
	logic [data_w-1:0]   data_wdata;
	logic [data_w-1:0]   rdata0;
	logic [data_w-1:0]   rdata1;
	logic                mem_start;
	mem_req_t            port_req;
	logic                mem_done;
	logic [data_w-1:0]   mem_word;

	dcache_req_stage u_req_stage (
		.clk        (clk),
		.rst        (rst),
		.req_i      (req_i),
		.req_data_i (req_data_i),
		.ack_i      (ack_o),
		.new_req_o  (new_req),
		.held_req_o (held_req)
	);

	dcache_ctrl u_ctrl (
		.clk            (clk),
		.rst            (rst),
		.new_req_i      (new_req),
		.req_i          (held_req),
		.entry0_i       (entry0),
		.entry1_i       (entry1),
		.dirty_i        (dirty),
		.lru_way_i      (lru_way),
		.rdata0_i       (rdata0),
		.rdata1_i       (rdata1),
		.mem_done_i     (mem_done),
		.mem_rdata_i    (mem_word),
		.index_o        (index),
		.tag_wr_en_o    (tag_wr_en),
		.tag_wr_way_o   (tag_wr_way),
		.tag_wr_entry_o (tag_wr_entry),
		.set_dirty_o    (set_dirty),
		.clr_dirty_o    (clr_dirty),
		.touch_o        (touch),
		.touch_way_o    (touch_way),
		.data_wr_en_o   (data_wr_en),
		.data_way_o     (data_way),
		.data_mask_o    (data_mask),
		.data_wdata_o   (data_wdata),
		.mem_start_o    (mem_start),
		.mem_req_o      (port_req),
		.ack_o          (ack_o),
		.rdata_o        (rdata_o)
	);

	dcache_tag_store u_tag_store (
		.clk         (clk),
		.rst         (rst),
		.rd_index_i  (index),
		.wr_en_i     (tag_wr_en),
		.wr_way_i    (tag_wr_way),
		.wr_entry_i  (tag_wr_entry),
		.set_dirty_i (set_dirty),
		.clr_dirty_i (clr_dirty),
		.touch_i     (touch),
		.touch_way_i (touch_way),
		.entry0_o    (entry0),
		.entry1_o    (entry1),
		.dirty_o     (dirty),
		.lru_way_o   (lru_way)
	);

	dcache_data_store u_data_store (
		.clk      (clk),
		.index_i  (index),
		.wr_en_i  (data_wr_en),
		.way_i    (data_way),
		.mask_i   (data_mask),
		.wdata_i  (data_wdata),
		.rdata0_o (rdata0),
		.rdata1_o (rdata1)
	);

	dcache_mem_port u_mem_port (
		.clk         (clk),
		.rst         (rst),
		.start_i     (mem_start),
		.req_i       (port_req),
		.mem_valid_i (mem_valid_i),
		.mem_rdata_i (mem_rdata_i),
		.mem_req_o   (mem_req_o),
		.done_o      (mem_done),
		.rdata_o     (mem_word)
	);

endmodule

// ==== dcache_props.sv ====
// cache handshake properties
`timescale 1ns/10ps

module dcache_props
	import dcache_pkg::*;
(
	input logic     clk,
	input logic     rst,
	input logic     ack_i,
	input mem_req_t mem_req_i,
	input logic     mem_valid_i
);

	logic mem_active;
	int   fail_count = 0;

	assign mem_active = mem_req_i.rd_en || mem_req_i.wr_en;

	one_enable: assert property (@(posedge clk) disable iff (!rst)
		!(mem_req_i.rd_en && mem_req_i.wr_en))
		else begin
			$error("memory read and write enables high together");
			fail_count++;
		end

	ack_pulse: assert property (@(posedge clk) disable iff (!rst)
		ack_i |=> !ack_i)
		else begin
			$error("ack held for more than one cycle");
			fail_count++;
		end

	// request stays on the bus until the memory answers
	addr_hold: assert property (@(posedge clk) disable iff (!rst)
		mem_active && !mem_valid_i |=> mem_active && $stable(mem_req_i.addr))
		else begin
			$error("memory address or enable changed before mem_valid_i");
			fail_count++;
		end

	wdata_hold: assert property (@(posedge clk) disable iff (!rst)
		mem_req_i.wr_en && !mem_valid_i |=> $stable(mem_req_i.wdata))
		else begin
			$error("memory write data changed before mem_valid_i");
			fail_count++;
		end

endmodule

bind dcache_top dcache_props u_props (
	.clk         (clk),
	.rst         (rst),
	.ack_i       (ack_o),
	.mem_req_i   (mem_req_o),
	.mem_valid_i (mem_valid_i)
);

// ==== tb_dcache.sv ====
// data cache testbench
`timescale 1ns/10ps

module tb_dcache
	import dcache_pkg::*;
();

	localparam int ack_limit = 200;

	typedef struct packed {
		logic        write;
		logic [31:0] addr;
		logic [63:0] wdata;
		logic [7:0]  mask;
		int          reads;
		int          writes;
		logic [31:0] wb_addr;
	} op_t;

	logic              clk;
	logic              rst;
	logic              req_i;
	core_req_t         req_data_i;
	logic              ack_o;
	logic [data_w-1:0] rdata_o;
	mem_req_t          mem_req_o;
	logic              mem_valid_i;
	logic [data_w-1:0] mem_rdata_i;

	logic [31:0] lcg_state;
	logic [63:0] mem_store [logic [31:0]];
	logic [63:0] ref_store [logic [31:0]];
	logic [31:0] rd_addrs [$];
	logic [31:0] wr_addrs [$];
	op_t         ops [$];
	logic        mem_busy;
	int          mem_count;
	int          errors;
	int          n_pass;
	int          n_fail;
	logic        timed_out;

	dcache_top dut_i (
		.clk         (clk),
		.rst         (rst),
		.req_i       (req_i),
		.req_data_i  (req_data_i),
		.ack_o       (ack_o),
		.rdata_o     (rdata_o),
		.mem_req_o   (mem_req_o),
		.mem_valid_i (mem_valid_i),
		.mem_rdata_i (mem_rdata_i)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// power-up memory contents
	function automatic logic [63:0] init_word(input logic [31:0] a);
		return {a ^ 32'h3c5a96e1, {a[15:0], a[31:16]} + 32'h01234567};
	endfunction

	function automatic logic [63:0] mem_word(input logic [31:0] a);
		logic [31:0] key;
		key = {a[31:3], 3'b000};
		if (mem_store.exists(key)) begin
			return mem_store[key];
		end else begin
			return init_word(key);
		end
	endfunction

	// byte-level shadow of what the core should see
	function automatic logic [63:0] ref_word(input logic [31:0] a);
		logic [31:0] key;
		key = {a[31:3], 3'b000};
		if (ref_store.exists(key)) begin
			return ref_store[key];
		end else begin
			return init_word(key);
		end
	endfunction

	function automatic void ref_write(input logic [31:0] a, input logic [63:0] d,
			input logic [7:0] m);
		logic [63:0] w;
		w = ref_word(a);
		for (int b = 0; b < 8; b++) begin
			if (m[b]) begin
				w[b*8 +: 8] = d[b*8 +: 8];
			end
		end
		ref_store[{a[31:3], 3'b000}] = w;
	endfunction

	function automatic void add_op(input logic write, input logic [31:0] addr,
			input logic [63:0] wdata, input logic [7:0] mask, input int reads,
			input int writes, input logic [31:0] wb_addr);
		op_t op;
		op.write = write;
		op.addr = addr;
		op.wdata = wdata;
		op.mask = mask;
		op.reads = reads;
		op.writes = writes;
		op.wb_addr = wb_addr;
		ops.push_back(op);
	endfunction

	// write, addr, wdata, mask, mem reads, mem writes, write-back addr
	function automatic void build_table();
		// first read, hit, masked write and merge in set 5
		add_op(1'b0, 32'h0000_102c, 64'h0, 8'h00, 1, 0, 32'h0);
		add_op(1'b0, 32'h0000_102c, 64'h0, 8'h00, 0, 0, 32'h0);
		add_op(1'b1, 32'h0000_102c, 64'h1122_3344_5566_7788, 8'hf0, 0, 0, 32'h0);
		add_op(1'b0, 32'h0000_102c, 64'h0, 8'h00, 0, 0, 32'h0);
		// two more tags in the same set push the dirty line out
		add_op(1'b0, 32'h0000_2028, 64'h0, 8'h00, 1, 0, 32'h0);
		add_op(1'b0, 32'h0000_3028, 64'h0, 8'h00, 1, 1, 32'h0000_1028);
		add_op(1'b0, 32'h0000_102c, 64'h0, 8'h00, 1, 0, 32'h0);
		// in set 9 C evicts B after A B A
		add_op(1'b0, 32'h0000_4048, 64'h0, 8'h00, 1, 0, 32'h0);
		add_op(1'b0, 32'h0000_8048, 64'h0, 8'h00, 1, 0, 32'h0);
		add_op(1'b0, 32'h0000_4048, 64'h0, 8'h00, 0, 0, 32'h0);
		add_op(1'b0, 32'h0000_c048, 64'h0, 8'h00, 1, 0, 32'h0);
		add_op(1'b0, 32'h0000_4048, 64'h0, 8'h00, 0, 0, 32'h0);
		add_op(1'b0, 32'h0000_8048, 64'h0, 8'h00, 1, 0, 32'h0);
		// write miss allocates
		add_op(1'b1, 32'h0000_0114, 64'ha5a5_5a5a_0ff0_f00f, 8'h81, 1, 0, 32'h0);
		add_op(1'b0, 32'h0000_0110, 64'h0, 8'h00, 0, 0, 32'h0);
	endfunction

	// memory model answering after 1 to 4 cycles
	always @(posedge clk) begin
		#1;
		if (!rst) begin
			mem_valid_i = 1'b0;
			mem_busy = 1'b0;
		end else if (mem_valid_i) begin
			mem_valid_i = 1'b0;
		end else if (mem_busy) begin
			if (mem_count == 0) begin
				if (mem_req_o.wr_en) begin
					mem_store[{mem_req_o.addr[31:3], 3'b000}] = mem_req_o.wdata;
				end else begin
					mem_rdata_i = mem_word(mem_req_o.addr);
				end
				mem_valid_i = 1'b1;
				mem_busy = 1'b0;
			end else begin
				mem_count = mem_count - 1;
			end
		end else if (mem_req_o.rd_en || mem_req_o.wr_en) begin
			mem_busy = 1'b1;
			mem_count = int'(next_rand() % 32'd4);
			if (mem_req_o.rd_en) begin
				rd_addrs.push_back(mem_req_o.addr);
			end else begin
				wr_addrs.push_back(mem_req_o.addr);
			end
		end
	end

	task automatic report_test(input int num, input string what, input int errs_before);
		if (errors == errs_before) begin
			n_pass++;
			$display("test %0d %s: ok", num, what);
		end else begin
			n_fail++;
			$display("test %0d %s: failed", num, what);
		end
	endtask

	task automatic check_idle();
		int errs_before;
		errs_before = errors;
		for (int c = 0; c < 12; c++) begin
			@(negedge clk);
			assert (!ack_o && !mem_req_o.rd_en && !mem_req_o.wr_en) else begin
				$display("** Error at %0t: ack or memory enable active while idle", $time);
				errors++;
			end
		end
		report_test(0, "idle after reset", errs_before);
	endtask

	task automatic run_op(input int num, input op_t op);
		logic [63:0] got;
		logic [63:0] expect_word;
		logic [31:0] line_addr;
		string       what;
		int          cycles;
		int          errs_before;
		logic        seen;
		errs_before = errors;
		what = $sformatf("%s %h", op.write ? "write" : "read", op.addr);
		line_addr = {op.addr[31:3], 3'b000};
		expect_word = ref_word(op.addr);
		@(posedge clk);
		#1;
		rd_addrs.delete();
		wr_addrs.delete();
		req_data_i.addr.flat = op.addr;
		req_data_i.write = op.write;
		req_data_i.wdata = op.wdata;
		req_data_i.mask = op.mask;
		req_i = 1'b1;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < ack_limit) begin
			@(negedge clk);
			cycles++;
			seen = ack_o;
		end
		got = rdata_o;
		@(posedge clk);
		#1;
		req_i = 1'b0;
		if (!seen) begin
			$display("test %0d: the cache gave no acknowledge within %0d cycles",
				num, ack_limit);
			errors++;
			timed_out = 1'b1;
		end else begin
			if (!op.write) begin
				assert (got === expect_word) else begin
					$display("** Error at %0t: test %0d read returned %h, expected %h",
						$time, num, got, expect_word);
					errors++;
				end
			end
			assert (rd_addrs.size() == op.reads) else begin
				$display("** Error at %0t: test %0d made %0d memory reads, expected %0d",
					$time, num, rd_addrs.size(), op.reads);
				errors++;
			end
			if (op.reads == 1 && rd_addrs.size() == 1) begin
				assert (rd_addrs[0] == line_addr) else begin
					$display("** Error at %0t: test %0d refill address %h, expected %h",
						$time, num, rd_addrs[0], line_addr);
					errors++;
				end
			end
			assert (wr_addrs.size() == op.writes) else begin
				$display("** Error at %0t: test %0d made %0d memory writes, expected %0d",
					$time, num, wr_addrs.size(), op.writes);
				errors++;
			end
			if (op.writes == 1 && wr_addrs.size() == 1) begin
				assert (wr_addrs[0] == op.wb_addr) else begin
					$display("** Error at %0t: test %0d write-back address %h, expected %h",
						$time, num, wr_addrs[0], op.wb_addr);
					errors++;
				end
				assert (mem_word(op.wb_addr) == ref_word(op.wb_addr)) else begin
					$display("** Error at %0t: test %0d write-back data %h, expected %h",
						$time, num, mem_word(op.wb_addr), ref_word(op.wb_addr));
					errors++;
				end
			end
			if (op.write) begin
				ref_write(op.addr, op.wdata, op.mask);
			end
		end
		report_test(num, what, errs_before);
	endtask

	initial begin
		rst = 1'b0;
		req_i = 1'b0;
		req_data_i = '0;
		mem_valid_i = 1'b0;
		mem_rdata_i = '0;
		mem_busy = 1'b0;
		mem_count = 0;
		lcg_state = 32'hc7f2c4da;
		errors = 0;
		n_pass = 0;
		n_fail = 0;
		timed_out = 1'b0;
		build_table();
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b1;
		check_idle();
		for (int i = 0; i < ops.size() && !timed_out; i++) begin
			run_op(i + 1, ops[i]);
		end
		if (dut_i.u_props.fail_count != 0) begin
			$display("the handshake properties failed %0d times",
				dut_i.u_props.fail_count);
			errors += dut_i.u_props.fail_count;
		end
		$display("tests: %0d, passed: %0d, failed: %0d", n_pass + n_fail, n_pass, n_fail);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== build.f ====
dcache_pkg.sv
dcache_req_stage.sv
dcache_tag_store.sv
dcache_data_store.sv
dcache_ctrl.sv
dcache_mem_port.sv
dcache_top.sv
dcache_props.sv
tb_dcache.sv

// ==== Makefile ====
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= NO ERRORS

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
